// File: fskDemod_params.svh
// fsk demod widths and constants
`ifndef FSKDEMOD_PARAMS_SVH
`define FSKDEMOD_PARAMS_SVH

// --------------------------------------------------
// datapath widths
`define SAMPLE_W    12
`define COEF_W      12
`define FILT_W      16
`define FILT_SHIFT  10      // drop from the 26 bit tap sum

// symbols between a legacy bit and its decision
`define BER_LAG     2

// --------------------------------------------------
// tone 0 taps, two samples per symbol
`define F0_C0_RE    12'h6D2
`define F0_C0_IM    12'h42E
`define F0_C1_RE    12'hF5F
`define F0_C1_IM    12'h7F9

// tone 1 taps, only the imaginary parts differ
`define F1_C0_RE    12'h6D2
`define F1_C0_IM    12'hBD1
`define F1_C1_RE    12'hF5F
`define F1_C1_IM    12'h806

// register offsets
`define REG_BER     12'h000
`define REG_CTRL    12'h004

`endif

// File: demodPkg.sv
// signal path types
package demodPkg;

  `include "fskDemod_params.svh"

  // --------------------------------------------------
  // input side

  // one I or Q sample from the front end
  typedef logic signed [`SAMPLE_W-1:0] sampleT;

  // matched filter tap, one real or imaginary part
  typedef logic signed [`COEF_W-1:0] coefT;

  // --------------------------------------------------
  // filter and detector side

  // scaled filter output, I or Q
  typedef logic signed [`FILT_W-1:0] filtT;

  // I squared plus Q squared, never negative
  // one extra bit so the sum of two full squares fits
  typedef logic [2*`FILT_W:0] energyT;

endpackage

// File: regPkg.sv
// APB register types
package regPkg;

  `include "fskDemod_params.svh"

  typedef logic [11:0] apbAddrT;   // byte address inside the block
  typedef logic [31:0] apbDataT;

  // bit and error counters, packed side by side in REG_BER
  typedef logic [15:0] berCountT;

endpackage

// File: matchedFilter.sv
// two-tap complex matched filter
`timescale 1ns/1ps
`include "fskDemod_params.svh"

module matchedFilter import demodPkg::*; #(
  parameter coefT C0Re = '0,
  parameter coefT C0Im = '0,
  parameter coefT C1Re = '0,
  parameter coefT C1Im = '0
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   sampleEn,
  input  logic   symEn,
  input  sampleT iIn,
  input  sampleT qIn,
  output filtT   filtI,
  output filtT   filtQ,
  output logic   filtValid
);

  localparam int PROD_W = `SAMPLE_W + `COEF_W + 1;   // one complex tap, re or im part
  localparam int SUM_W  = PROD_W + 1;

  sampleT                   prevI;
  sampleT                   prevQ;
  logic signed [PROD_W-1:0] t0Re;
  logic signed [PROD_W-1:0] t0Im;
  logic signed [PROD_W-1:0] t1Re;
  logic signed [PROD_W-1:0] t1Im;
  logic signed [PROD_W-1:0] p0Re;
  logic signed [PROD_W-1:0] p0Im;
  logic signed [PROD_W-1:0] p1Re;
  logic signed [PROD_W-1:0] p1Im;
  logic signed [SUM_W-1:0]  sumI;
  logic signed [SUM_W-1:0]  sumQ;
  logic                     prodValid;

  always_ff @(posedge clk) begin
    if (sampleEn) begin
      prevI <= iIn;                   // first half of the symbol
      prevQ <= qIn;
    end
  end

  // --------------------------------------------------
  // stage 1 products
  // previous sample meets tap 0 and the current one tap 1
  always_comb begin
    t0Re = prevI * C0Re - prevQ * C0Im;
    t0Im = prevI * C0Im + prevQ * C0Re;
    t1Re = iIn * C1Re - qIn * C1Im;
    t1Im = iIn * C1Im + qIn * C1Re;
  end

  always_ff @(posedge clk) begin
    if (symEn) begin
      p0Re <= t0Re;
      p0Im <= t0Im;
      p1Re <= t1Re;
      p1Im <= t1Im;
    end
  end

  // --------------------------------------------------
  // stage 2 tap sum and scaling
  assign sumI = p0Re + p1Re;
  assign sumQ = p0Im + p1Im;

  always_ff @(posedge clk) begin
    if (prodValid) begin
      filtI <= sumI[`FILT_SHIFT +: `FILT_W];   // shift right, keep low bits
      filtQ <= sumQ[`FILT_SHIFT +: `FILT_W];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prodValid <= 1'b0;
      filtValid <= 1'b0;
    end else begin
      prodValid <= symEn;
      filtValid <= prodValid;
    end
  end

  // the symbol strobe always rides on a sample
  symOnSample: assert property (@(posedge clk) disable iff (reset) symEn |-> sampleEn)
    else $error("symEn high without sampleEn");

endmodule

// File: magnitudeDecision.sv
// tone energy compare
`timescale 1ns/1ps

module magnitudeDecision import demodPkg::*; (
  input  logic clk,
  input  logic reset,
  input  filtT f0I,
  input  filtT f0Q,
  input  filtT f1I,
  input  filtT f1Q,
  input  logic filtValid,
  output logic decision,
  output logic decisionValid
);

  energyT energy0;
  energyT energy1;
  logic   energyValid;

  // squares are never negative so the signed sum fits the unsigned type
  function automatic energyT energyOf(filtT re, filtT im);
    logic signed [$bits(energyT)-1:0] acc;
    acc = re * re + im * im;
    return acc;
  endfunction

  always_ff @(posedge clk) begin
    if (filtValid) begin
      energy0 <= energyOf(f0I, f0Q);
      energy1 <= energyOf(f1I, f1Q);
    end
  end

  // ties go to tone 0
  always_ff @(posedge clk) begin
    if (reset) begin
      energyValid   <= 1'b0;
      decisionValid <= 1'b0;
      decision      <= 1'b0;
    end else begin
      energyValid   <= filtValid;
      decisionValid <= energyValid;
      if (energyValid) begin
        decision <= (energy1 > energy0);   // held until the next symbol
      end
    end
  end

  // symbols are spaced well apart upstream, so decisions never come back to back
  singlePulse: assert property (@(posedge clk) disable iff (reset)
    decisionValid |=> !decisionValid)
    else $error("decisionValid high on consecutive cycles");

endmodule

// File: berMonitor.sv
// bit error monitor with APB registers
`timescale 1ns/1ps
`include "fskDemod_params.svh"

module berMonitor import regPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    symEn,
  input  logic    legacyBit,
  input  logic    decision,
  input  logic    decisionValid,
  input  logic    psel,
  input  logic    penable,
  input  logic    pwrite,
  input  apbAddrT paddr,
  input  apbDataT pwdata,
  output apbDataT prdata,
  output logic    pready,
  output logic    pslverr
);

  localparam int HIST_W = `BER_LAG + 2;   // lag plus two symbols in flight
  localparam int IDX_W  = $clog2(HIST_W);

  logic [HIST_W-1:0] legacyHist;
  logic [1:0]        inFlight;
  logic [IDX_W-1:0]  tapIdx;
  logic              legacyTap;
  berCountT          bitCount;
  berCountT          errCount;
  logic              accessPhase;
  logic              berHit;
  logic              ctrlHit;
  logic              restart;

  // --------------------------------------------------
  // legacy history and symbols in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      legacyHist <= '0;
    end else if (symEn) begin
      legacyHist <= {legacyHist[HIST_W-2:0], legacyBit};   // bit 0 is the newest symbol
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      inFlight <= '0;
    end else begin
      case ({symEn, decisionValid})
        2'b10:   inFlight <= inFlight + 2'd1;
        2'b01:   inFlight <= inFlight - 2'd1;
        default: inFlight <= inFlight;   // both or neither
      endcase
    end
  end

  // decided symbol sits at inFlight-1, then BER_LAG further back
  assign tapIdx    = IDX_W'(`BER_LAG - 1) + IDX_W'(inFlight);
  assign legacyTap = legacyHist[tapIdx];

  // --------------------------------------------------
  // counters
  // counting stops once the bit count runs down to zero
  always_ff @(posedge clk) begin
    if (reset || restart) begin
      bitCount <= '1;
      errCount <= '0;
    end else if (decisionValid && (bitCount != '0)) begin
      bitCount <= bitCount - berCountT'(1);
      if (decision != legacyTap) begin
        errCount <= errCount + berCountT'(1);
      end
    end
  end

  // --------------------------------------------------
  // APB slave, zero wait states
  assign accessPhase = psel && penable;
  assign berHit      = (paddr == `REG_BER);
  assign ctrlHit     = (paddr == `REG_CTRL);
  assign restart     = accessPhase && pwrite && ctrlHit && pwdata[0];

  assign pready  = 1'b1;
  assign pslverr = accessPhase && !(berHit || ctrlHit);
  assign prdata  = (psel && !pwrite && berHit) ? {errCount, bitCount} : '0;

  // pipeline latency against symbol spacing bounds the backlog
  inFlightMax: assert property (@(posedge clk) disable iff (reset) inFlight <= 2'd2)
    else $error("more than two symbols in flight");

endmodule

// File: fskDemod.sv
// two-tone symbol detector top
`timescale 1ns/1ps
`include "fskDemod_params.svh"

module fskDemod import demodPkg::*, regPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    sampleEn,
  input  logic    symEn,
  input  sampleT  iIn,
  input  sampleT  qIn,
  input  logic    legacyBit,
  output logic    decision,
  output logic    decisionValid,
  input  logic    psel,
  input  logic    penable,
  input  logic    pwrite,
  input  apbAddrT paddr,
  input  apbDataT pwdata,
  output apbDataT prdata,
  output logic    pready,
  output logic    pslverr
);

  filtT f0I;
  filtT f0Q;
  filtT f1I;
  filtT f1Q;
  logic f0Valid;

  // --------------------------------------------------
  // one filter per tone, both in lockstep
  matchedFilter #(
    .C0Re(`F0_C0_RE), .C0Im(`F0_C0_IM), .C1Re(`F0_C1_RE), .C1Im(`F0_C1_IM)
  ) f0Filter (
    .clk(clk), .reset(reset), .sampleEn(sampleEn), .symEn(symEn),
    .iIn(iIn), .qIn(qIn),
    .filtI(f0I), .filtQ(f0Q), .filtValid(f0Valid)
  );

  matchedFilter #(
    .C0Re(`F1_C0_RE), .C0Im(`F1_C0_IM), .C1Re(`F1_C1_RE), .C1Im(`F1_C1_IM)
  ) f1Filter (
    .clk(clk), .reset(reset), .sampleEn(sampleEn), .symEn(symEn),
    .iIn(iIn), .qIn(qIn),
    .filtI(f1I), .filtQ(f1Q), .filtValid()   // same timing as f0
  );

  magnitudeDecision magnitudeDecision_inst (
    .clk(clk), .reset(reset),
    .f0I(f0I), .f0Q(f0Q), .f1I(f1I), .f1Q(f1Q),
    .filtValid(f0Valid),
    .decision(decision), .decisionValid(decisionValid)
  );

  // --------------------------------------------------
  // error monitor and registers
  berMonitor berMonitor_inst (
    .clk(clk), .reset(reset),
    .symEn(symEn), .legacyBit(legacyBit),
    .decision(decision), .decisionValid(decisionValid),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

endmodule

// File: tbFskDemod.sv
// two-tone detector testbench
`timescale 1ns/1ps
`include "fskDemod_params.svh"

module tbFskDemod
  import demodPkg::*, regPkg::*;
();

  localparam int CLK_PERIOD    = 8;
  localparam int LATENCY       = 4;    // strobe to decisionValid, in cycles
  localparam int DRAIN_TIMEOUT = 32;
  localparam int APB_TIMEOUT   = 8;

  logic    clk;
  logic    reset;
  logic    sampleEn;
  logic    symEn;
  sampleT  iIn;
  sampleT  qIn;
  logic    legacyBit;
  logic    decision;
  logic    decisionValid;
  logic    psel;
  logic    penable;
  logic    pwrite;
  apbAddrT paddr;
  apbDataT pwdata;
  apbDataT prdata;
  logic    pready;
  logic    pslverr;

  logic [31:0] rngState;
  int          cycle;
  logic        expQueue[$];      // expected decisions, oldest first
  int          strobeQueue[$];   // cycle of each symbol strobe
  logic        legacyList[$];    // every legacy bit since reset
  int          decidedCount;
  berCountT    modelBits;
  berCountT    modelErrs;
  logic        lastDecision;
  logic        haveDecision;

  fskDemod fskDemod_inst (
    .clk(clk), .reset(reset),
    .sampleEn(sampleEn), .symEn(symEn), .iIn(iIn), .qIn(qIn),
    .legacyBit(legacyBit),
    .decision(decision), .decisionValid(decisionValid),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // --------------------------------------------------
  // random numbers and reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // previous sample on tap 0, current sample on tap 1, then scale
  function automatic void tapFilter(
    input sampleT i0, input sampleT q0, input sampleT i1, input sampleT q1,
    input coefT c0Re, input coefT c0Im, input coefT c1Re, input coefT c1Im,
    output filtT fI, output filtT fQ
  );
    longint sumRe;
    longint sumIm;
    sumRe = (longint'(i0) * c0Re - longint'(q0) * c0Im)
          + (longint'(i1) * c1Re - longint'(q1) * c1Im);
    sumIm = (longint'(i0) * c0Im + longint'(q0) * c0Re)
          + (longint'(i1) * c1Im + longint'(q1) * c1Re);
    fI = filtT'(sumRe >>> `FILT_SHIFT);
    fQ = filtT'(sumIm >>> `FILT_SHIFT);
  endfunction

  function automatic logic refDecision(sampleT i0, sampleT q0, sampleT i1, sampleT q1);
    filtT   f0I;
    filtT   f0Q;
    filtT   f1I;
    filtT   f1Q;
    longint e0;
    longint e1;
    tapFilter(i0, q0, i1, q1, `F0_C0_RE, `F0_C0_IM, `F0_C1_RE, `F0_C1_IM, f0I, f0Q);
    tapFilter(i0, q0, i1, q1, `F1_C0_RE, `F1_C0_IM, `F1_C1_RE, `F1_C1_IM, f1I, f1Q);
    e0 = longint'(f0I) * f0I + longint'(f0Q) * f0Q;
    e1 = longint'(f1I) * f1I + longint'(f1Q) * f1Q;
    return e1 > e0;   // a tie is tone 0
  endfunction

  // --------------------------------------------------
  // compare tasks

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkDecision(input string name, input logic got, input logic exp);
    if (got !== exp)
      failNow($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkBer(input string name, input berCountT gotErr, input berCountT gotBits,
                          input berCountT expErr, input berCountT expBits);
    if (gotErr !== expErr || gotBits !== expBits)
      failNow($sformatf("FAILED %s: got errors %h bits %h expected errors %h bits %h",
                        name, gotErr, gotBits, expErr, expBits));
  endtask

  task automatic checkResp(input string name, input logic got, input logic exp);
    if (got !== exp)
      failNow($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  // decisions in order, fixed latency, BER model alongside
  always @(negedge clk) begin
    logic expDec;
    int   strobeAt;
    logic legacyRef;
    if (!reset && decisionValid) begin
      if (expQueue.size() == 0) begin
        failNow("decisionValid went high with no symbol pending");
      end else begin
        expDec   = expQueue.pop_front();
        strobeAt = strobeQueue.pop_front();
        checkDecision("decision", decision, expDec);
        if (cycle - strobeAt != LATENCY)
          failNow($sformatf("decision came %0d cycles after its symbol strobe, expected %0d",
                            cycle - strobeAt, LATENCY));
        legacyRef = (decidedCount >= `BER_LAG) ? legacyList[decidedCount - `BER_LAG] : 1'b0;
        if (modelBits != 0) begin
          modelBits = modelBits - 1;
          if (expDec != legacyRef) modelErrs = modelErrs + 1;
        end
        decidedCount = decidedCount + 1;
        lastDecision = expDec;
        haveDecision = 1'b1;
      end
    end else if (!reset && haveDecision) begin
      checkDecision("decision", decision, lastDecision);   // held between pulses
    end
  end

  // --------------------------------------------------
  // stream and APB drivers

  task automatic driveIdle();
    logic [31:0] r;
    @(negedge clk);
    r         = nextRand();
    sampleEn  = 1'b0;
    symEn     = 1'b0;
    iIn       = sampleT'(r);         // junk between samples
    qIn       = sampleT'(r >> 12);
    legacyBit = r[31];
  endtask

  // one symbol of two samples, strobes exactly spacing cycles apart
  task automatic sendSymbol(input int spacing);
    int          lead;
    int          gap;
    logic [31:0] r;
    sampleT      i0;
    sampleT      q0;
    sampleT      i1;
    sampleT      q1;
    lead = 1 + int'(nextRand() % (spacing - 3));
    gap  = spacing - 1 - lead;
    repeat (lead) driveIdle();
    @(negedge clk);
    r        = nextRand();
    i0       = sampleT'(r);
    q0       = sampleT'(r >> 16);
    sampleEn = 1'b1;
    symEn    = 1'b0;
    iIn      = i0;
    qIn      = q0;
    repeat (gap - 1) driveIdle();
    @(negedge clk);
    r         = nextRand();
    i1        = sampleT'(r);
    q1        = sampleT'(r >> 16);
    sampleEn  = 1'b1;
    symEn     = 1'b1;
    iIn       = i1;
    qIn       = q1;
    legacyBit = r[31];
    expQueue.push_back(refDecision(i0, q0, i1, q1));
    strobeQueue.push_back(cycle);
    legacyList.push_back(r[31]);
  endtask

  task automatic sendStream(input int count, input logic minSpacing);
    repeat (count) begin
      if (minSpacing) sendSymbol(4);
      else sendSymbol(4 + int'(nextRand() % 4));
    end
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    while (expQueue.size() != 0) begin
      if (waited == DRAIN_TIMEOUT) begin
        failNow("timeout waiting for pending decisions");
      end else begin
        driveIdle();
        waited = waited + 1;
      end
    end
  endtask

  // results taken one negedge after the completing edge
  task automatic apbTransfer(input logic write, input apbAddrT addr, input apbDataT wdata,
                             output apbDataT rdata, output logic err, output logic rdy);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    rdy = pready;   // first access cycle, high with zero wait states
    while (!pready) begin
      if (waited == APB_TIMEOUT) begin
        failNow("timeout waiting for pready");
      end else begin
        waited = waited + 1;
        @(negedge clk);
      end
    end
    rdata   = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic readBer();
    apbDataT d;
    logic    err;
    logic    rdy;
    apbTransfer(1'b0, `REG_BER, '0, d, err, rdy);
    checkResp("pready", rdy, 1'b1);
    checkResp("pslverr", err, 1'b0);
    checkBer("REG_BER", d[31:16], d[15:0], modelErrs, modelBits);
  endtask

  task automatic readUnmapped(input apbAddrT addr);
    apbDataT d;
    logic    err;
    logic    rdy;
    apbTransfer(1'b0, addr, '0, d, err, rdy);
    checkResp("pready", rdy, 1'b1);
    checkResp("pslverr", err, 1'b1);
    checkBer("prdata", d[31:16], d[15:0], '0, '0);
  endtask

  // --------------------------------------------------
  // main sequence
  initial begin
    apbDataT d;
    logic    err;
    logic    rdy;
    rngState     = 32'hb627_c872;
    cycle        = 0;
    decidedCount = 0;
    modelBits    = '1;
    modelErrs    = '0;
    lastDecision = 1'b0;
    haveDecision = 1'b0;
    reset        = 1'b1;
    sampleEn     = 1'b0;
    symEn        = 1'b0;
    iIn          = '0;
    qIn          = '0;
    legacyBit    = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    repeat (10) driveIdle();   // nothing may come out yet
    readBer();

    sendStream(60, 1'b0);
    waitDrain();
    readBer();

    sendStream(60, 1'b1);      // back to back at 4 cycles
    waitDrain();
    readBer();

    apbTransfer(1'b1, `REG_CTRL, 32'h1, d, err, rdy);
    checkResp("pslverr", err, 1'b0);
    modelBits = '1;
    modelErrs = '0;
    readBer();

    sendStream(40, 1'b0);
    waitDrain();
    readBer();

    readUnmapped(12'h008);
    readUnmapped(12'hFFC);

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: src.f
+incdir+.
demodPkg.sv
regPkg.sv
matchedFilter.sv
magnitudeDecision.sv
berMonitor.sv
fskDemod.sv
tbFskDemod.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbFskDemod
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
